// File: lane_apb_port.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module lane_apb_port (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [7:0]                 paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [`LANE_DATA_W-1:0]    pwdata,
	output logic [`LANE_DATA_W-1:0]    prdata,
	output logic                       pready,
	output logic                       pslverr,
	output logic                       cmd_valid,
	output lane_pkg::lane_instr_t      cmd_word,
	input  logic                       cmd_accept,
	input  logic                       pipe_idle,
	output lane_pkg::lane_host_t       host,
	input  logic [`LANE_DATA_W-1:0]    host_rdata,
	input  logic [`LANE_DATA_W-1:0]    status
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_IDLE,
		ACCESS,
		DONE
	} port_state_e;

	port_state_e state;
	port_state_e state_nxt;
	logic        access;
	logic        is_cmd;
	logic        is_status;
	logic        is_reg;
	logic        bad_addr;
	logic [7:0]  reg_off;

	////////////////////////////////////////////////////////////////////////////
	// Offset decode
	assign access    = psel && penable;         // Access phase
	assign is_cmd    = paddr == `LANE_ADDR_CMD;
	assign is_status = paddr == `LANE_ADDR_STATUS;
	assign reg_off   = paddr - `LANE_ADDR_REG_BASE;
	assign is_reg    = (reg_off < 8'(4 * `LANE_NUM_REGS)) && (reg_off[1:0] == 2'b00);

	// CMD is write only, STATUS read only
	assign bad_addr  = pwrite ? !(is_cmd || is_reg) : !(is_status || is_reg);

	assign cmd_word  = lane_pkg::lane_instr_t'(pwdata);

	////////////////////////////////////////////////////////////////////////////
	// Register access FSM, waits for an empty pipeline
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (access && is_reg) begin
					state_nxt = pipe_idle ? ACCESS : WAIT_IDLE;
				end
			end
			WAIT_IDLE: begin
				if (pipe_idle) begin
					state_nxt = ACCESS;
				end
			end
			ACCESS:  state_nxt = DONE;   // Regfile captures here
			DONE:    state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	// One cycle request to the regfile
	assign host.rd    = (state == ACCESS) && !pwrite;
	assign host.wr    = (state == ACCESS) && pwrite;
	assign host.idx   = reg_off[`LANE_IDX_W+1:2];
	assign host.wdata = pwdata;

	////////////////////////////////////////////////////////////////////////////
	// Response
	always_comb begin
		pready    = 1'b0;
		pslverr   = 1'b0;
		cmd_valid = 1'b0;
		prdata    = '0;
		if (access) begin
			if (bad_addr) begin
				pready  = 1'b1;
				pslverr = 1'b1;
			end else if (is_cmd) begin
				cmd_valid = 1'b1;
				pready    = cmd_accept;   // Back-pressure from decode
			end else if (is_status) begin
				pready = 1'b1;
				prdata = status;
			end else begin
				pready = state == DONE;
				if (!pwrite) begin
					prdata = host_rdata;
				end
			end
		end
	end

endmodule

// File: lane_decode.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module lane_decode (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       cmd_valid,
	input  lane_pkg::lane_instr_t      cmd_word,
	output logic                       cmd_accept,
	output logic [`LANE_IDX_W-1:0]     rd_idx_a,
	output logic [`LANE_IDX_W-1:0]     rd_idx_b,
	input  logic [`LANE_DATA_W-1:0]    rd_data_a,
	input  logic [`LANE_DATA_W-1:0]    rd_data_b,
	input  logic                       clr_valid,
	input  logic [`LANE_IDX_W-1:0]     clr_idx,
	output lane_pkg::lane_exe_t        exe,
	output logic [`LANE_NUM_REGS-1:0]  busy
);

	logic                       writes_reg;
	logic                       uses_a;
	logic                       uses_b;
	logic                       hazard;
	logic [`LANE_DATA_W-1:0]    imm_ext;
	logic [`LANE_NUM_REGS-1:0]  set_mask;
	logic [`LANE_NUM_REGS-1:0]  clr_mask;

	assign rd_idx_a = cmd_word.src1;
	assign rd_idx_b = cmd_word.src2;

	// Which registers this word touches
	assign writes_reg = lane_pkg::op_writes_reg(cmd_word.op);
	assign uses_a     = (writes_reg && (cmd_word.op != lane_pkg::OP_LDI)) ||
		lane_pkg::op_is_cmp(cmd_word.op);
	assign uses_b     = uses_a && !cmd_word.use_imm;

	assign hazard = (uses_a && busy[cmd_word.src1]) ||
		(uses_b && busy[cmd_word.src2]) ||
		(writes_reg && busy[cmd_word.dst]);

	assign cmd_accept = cmd_valid && !hazard;   // Stalls the APB master otherwise

	assign imm_ext = {{(`LANE_DATA_W-11){cmd_word.imm[10]}}, cmd_word.imm};

	////////////////////////////////////////////////////////////////////////////
	// Scoreboard, one busy bit per register in flight
	assign set_mask = (cmd_accept && writes_reg) ?
		(`LANE_NUM_REGS'(1) << cmd_word.dst) : '0;
	assign clr_mask = clr_valid ? (`LANE_NUM_REGS'(1) << clr_idx) : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			busy <= (busy & ~clr_mask) | set_mask;
		end
	end

	// Decode to execute register
	always_ff @(posedge clock) begin
		exe.op       <= cmd_word.op;
		exe.dst      <= cmd_word.dst;
		exe.a        <= rd_data_a;
		exe.b        <= (cmd_word.use_imm || (cmd_word.op == lane_pkg::OP_LDI)) ?
			imm_ext : rd_data_b;
		exe.mask_en  <= cmd_word.mask_en;
		exe.mask_sel <= cmd_word.mask_sel;
		if (reset) begin
			exe.valid <= 1'b0;
		end else begin
			exe.valid <= cmd_accept;
		end
	end

endmodule

// File: lane_execute.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module lane_execute (
	input  logic                        clock,
	input  logic                        reset,
	input  lane_pkg::lane_exe_t         exe,
	input  logic [`LANE_NUM_MASKS-1:0]  mask,
	output logic                        stage_valid,
	output lane_pkg::lane_wb_t          wb
);

	lane_pkg::lane_wb_t       s1;
	logic                     s1_mask_en;
	logic [2:0]               s1_mask_sel;
	logic [`LANE_DATA_W-1:0]  alu;
	logic                     mask_bit;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1: ALU
	always_comb begin
		case (exe.op)
			lane_pkg::OP_ADD:   alu = exe.a + exe.b;
			lane_pkg::OP_SUB:   alu = exe.a - exe.b;
			lane_pkg::OP_AND:   alu = exe.a & exe.b;
			lane_pkg::OP_OR:    alu = exe.a | exe.b;
			lane_pkg::OP_XOR:   alu = exe.a ^ exe.b;
			lane_pkg::OP_SHL:   alu = exe.a << exe.b[4:0];
			lane_pkg::OP_SHR:   alu = exe.a >> exe.b[4:0];
			lane_pkg::OP_MUL:   alu = exe.a * exe.b;
			lane_pkg::OP_LDI:   alu = exe.b;
			lane_pkg::OP_CMPLT: alu = `LANE_DATA_W'($signed(exe.a) < $signed(exe.b));
			lane_pkg::OP_CMPEQ: alu = `LANE_DATA_W'(exe.a == exe.b);
			default:            alu = '0;
		endcase
	end

	// NOP and unknown codes ride the mask path with the enable off
	always_ff @(posedge clock) begin
		s1.to_mask  <= !lane_pkg::op_writes_reg(exe.op);
		s1.en       <= lane_pkg::op_writes_reg(exe.op) || lane_pkg::op_is_cmp(exe.op);
		s1.dst      <= exe.dst;
		s1.data     <= alu;
		s1_mask_en  <= exe.mask_en;
		s1_mask_sel <= exe.mask_sel;
		if (reset) begin
			s1.valid <= 1'b0;
		end else begin
			s1.valid <= exe.valid;
		end
	end

	assign stage_valid = s1.valid;

	////////////////////////////////////////////////////////////////////////////
	// Stage 2: mask qualification
	assign mask_bit = mask[s1_mask_sel];

	always_ff @(posedge clock) begin
		wb.to_mask <= s1.to_mask;
		wb.en      <= s1.en && (!s1_mask_en || mask_bit);   // Masked off still commits
		wb.dst     <= s1.dst;
		wb.data    <= s1.data;
		if (reset) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= s1.valid;
		end
	end

endmodule

// File: lane_macros.svh
`ifndef LANE_MACROS_SVH
`define LANE_MACROS_SVH

// Datapath sizes
`define LANE_DATA_W         32
`define LANE_NUM_REGS       16
`define LANE_IDX_W          4
`define LANE_NUM_MASKS      8

////////////////////////////////////////////////////////////////////////////
// APB offsets of the lane
`define LANE_ADDR_CMD       8'h00   // Write only, issues one instruction
`define LANE_ADDR_STATUS    8'h04   // Read only
`define LANE_ADDR_REG_BASE  8'h40   // Registers at base + 4*idx, last at 0x7C

`endif

// File: lane_pkg.sv
package lane_pkg;

`include "lane_macros.svh"

	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_SHL   = 4'd6,   // Shift by b[4:0]
		OP_SHR   = 4'd7,
		OP_MUL   = 4'd8,   // Low half of product
		OP_LDI   = 4'd9,
		OP_CMPLT = 4'd10,  // Signed
		OP_CMPEQ = 4'd11
	} lane_op_e;

	// Instruction word as written to the CMD offset
	typedef struct packed {
		lane_op_e                op;
		logic [`LANE_IDX_W-1:0]  dst;       // Mask index in low bits for compares
		logic [`LANE_IDX_W-1:0]  src1;
		logic [`LANE_IDX_W-1:0]  src2;
		logic                    use_imm;
		logic                    mask_en;
		logic [2:0]              mask_sel;
		logic [10:0]             imm;
	} lane_instr_t;

	typedef struct packed {
		logic                    valid;
		lane_op_e                op;
		logic [`LANE_IDX_W-1:0]  dst;
		logic [`LANE_DATA_W-1:0] a;
		logic [`LANE_DATA_W-1:0] b;
		logic                    mask_en;
		logic [2:0]              mask_sel;
	} lane_exe_t;

	typedef struct packed {
		logic                    valid;
		logic                    to_mask;   // Not a register writer
		logic                    en;        // Clear when masked off
		logic [`LANE_IDX_W-1:0]  dst;
		logic [`LANE_DATA_W-1:0] data;
	} lane_wb_t;

	// Host side register access
	typedef struct packed {
		logic                    rd;
		logic                    wr;
		logic [`LANE_IDX_W-1:0]  idx;
		logic [`LANE_DATA_W-1:0] wdata;
	} lane_host_t;

	function automatic logic op_writes_reg(lane_op_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SHL, OP_SHR, OP_MUL, OP_LDI};
	endfunction

	function automatic logic op_is_cmp(lane_op_e op);
		return op inside {OP_CMPLT, OP_CMPEQ};
	endfunction

endpackage

// File: lane_regfile.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module lane_regfile (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`LANE_IDX_W-1:0]     rd_idx_a,
	input  logic [`LANE_IDX_W-1:0]     rd_idx_b,
	output logic [`LANE_DATA_W-1:0]    rd_data_a,
	output logic [`LANE_DATA_W-1:0]    rd_data_b,
	input  logic                       wb_en,
	input  logic [`LANE_IDX_W-1:0]     wb_idx,
	input  logic [`LANE_DATA_W-1:0]    wb_data,
	input  lane_pkg::lane_host_t       host,
	output logic [`LANE_DATA_W-1:0]    host_rdata
);

	logic [`LANE_DATA_W-1:0] regs [`LANE_NUM_REGS];

	// Operand fetch for decode
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

	// Host writes only happen with the pipeline empty
	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (host.wr) begin
			regs[host.idx] <= host.wdata;
		end else if (wb_en) begin
			regs[wb_idx] <= wb_data;
		end
	end

	always_ff @(posedge clock) begin
		if (host.rd) begin
			host_rdata <= regs[host.idx];   // Seen on prdata next cycle
		end
	end

endmodule

// File: lane_result.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module lane_result (
	input  logic                        clock,
	input  logic                        reset,
	input  lane_pkg::lane_wb_t          wb,
	input  logic [`LANE_NUM_REGS-1:0]   busy,
	input  logic                        exe_valid,
	input  logic                        exe_stage_valid,
	output logic                        wb_en,
	output logic [`LANE_IDX_W-1:0]      wb_idx,
	output logic [`LANE_DATA_W-1:0]     wb_data,
	output logic [`LANE_NUM_MASKS-1:0]  mask,
	output logic                        clr_valid,
	output logic [`LANE_IDX_W-1:0]      clr_idx,
	output logic                        pipe_idle,
	output logic [`LANE_DATA_W-1:0]     status
);

	logic [15:0] commit_cnt;
	logic        mask_we;

	// Register file write port
	assign wb_en   = wb.valid && wb.en && !wb.to_mask;
	assign wb_idx  = wb.dst;
	assign wb_data = wb.data;

	assign mask_we = wb.valid && wb.en && wb.to_mask;

	// Scoreboard release, also for masked-off writers
	assign clr_valid = wb.valid && !wb.to_mask;
	assign clr_idx   = wb.dst;

	always_ff @(posedge clock) begin
		if (reset) begin
			mask       <= '0;
			commit_cnt <= '0;
		end else begin
			if (mask_we) begin
				mask[wb.dst[2:0]] <= wb.data[0];
			end
			if (wb.valid) begin
				commit_cnt <= commit_cnt + 16'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Status word
	assign pipe_idle = (busy == '0) && !exe_valid && !exe_stage_valid && !wb.valid;
	assign status    = {7'd0, pipe_idle, mask, commit_cnt};

endmodule

// File: lane_unit.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module lane_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [7:0]                 paddr,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [`LANE_DATA_W-1:0]    pwdata,
	output logic [`LANE_DATA_W-1:0]    prdata,
	output logic                       pready,
	output logic                       pslverr
);

	logic                        cmd_valid;
	logic                        cmd_accept;
	lane_pkg::lane_instr_t       cmd_word;
	lane_pkg::lane_host_t        host;
	logic [`LANE_DATA_W-1:0]     host_rdata;
	logic [`LANE_DATA_W-1:0]     status;
	logic                        pipe_idle;
	logic [`LANE_IDX_W-1:0]      rd_idx_a;
	logic [`LANE_IDX_W-1:0]      rd_idx_b;
	logic [`LANE_DATA_W-1:0]     rd_data_a;
	logic [`LANE_DATA_W-1:0]     rd_data_b;
	logic                        wb_en;
	logic [`LANE_IDX_W-1:0]      wb_idx;
	logic [`LANE_DATA_W-1:0]     wb_data;
	lane_pkg::lane_exe_t         exe;
	lane_pkg::lane_wb_t          wb;
	logic                        exe_stage_valid;
	logic [`LANE_NUM_REGS-1:0]   busy;
	logic [`LANE_NUM_MASKS-1:0]  mask;
	logic                        clr_valid;
	logic [`LANE_IDX_W-1:0]      clr_idx;

	lane_apb_port apb_port (
		.clock      (clock),
		.reset      (reset),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.cmd_accept (cmd_accept),
		.pipe_idle  (pipe_idle),
		.host       (host),
		.host_rdata (host_rdata),
		.status     (status)
	);

	lane_regfile regfile (
		.clock      (clock),
		.reset      (reset),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.wb_en      (wb_en),
		.wb_idx     (wb_idx),
		.wb_data    (wb_data),
		.host       (host),
		.host_rdata (host_rdata)
	);

	// Pipeline: decode, two execute stages, result
	lane_decode decode (
		.clock      (clock),
		.reset      (reset),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.cmd_accept (cmd_accept),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.clr_valid  (clr_valid),
		.clr_idx    (clr_idx),
		.exe        (exe),
		.busy       (busy)
	);

	lane_execute execute (
		.clock       (clock),
		.reset       (reset),
		.exe         (exe),
		.mask        (mask),
		.stage_valid (exe_stage_valid),
		.wb          (wb)
	);

	lane_result result (
		.clock           (clock),
		.reset           (reset),
		.wb              (wb),
		.busy            (busy),
		.exe_valid       (exe.valid),
		.exe_stage_valid (exe_stage_valid),
		.wb_en           (wb_en),
		.wb_idx          (wb_idx),
		.wb_data         (wb_data),
		.mask            (mask),
		.clr_valid       (clr_valid),
		.clr_idx         (clr_idx),
		.pipe_idle       (pipe_idle),
		.status          (status)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_lane_unit -o sim_lane \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_lane > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tb.f
+incdir+.
lane_pkg.sv
lane_apb_port.sv
lane_regfile.sv
lane_decode.sv
lane_execute.sv
lane_result.sv
lane_unit.sv
tb_lane_unit.sv

// File: tb_lane_unit.sv
`timescale 1ns/100ps
`include "lane_macros.svh"

module tb_lane_unit;

	localparam int N_RANDOM = 300;
	localparam int N_ROUNDS = 40;     // Compare followed by two masked ops
	localparam int N_CHAIN  = 20;
	localparam int N_BAD    = 5;
	// APB transfers of all tests, each full check is 16 register reads and STATUS
	localparam int N_TRANSFERS = 17 + (16 + 17 + N_BAD) + (N_RANDOM + 17) +
		(3 * N_ROUNDS + 17) + (1 + 2 * N_CHAIN + 17) + 1;
	localparam int CYCLE_LIMIT = 40 * N_TRANSFERS;

	logic        clock;
	logic        reset;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] lcg_state;
	logic [31:0] model_regs [16];
	logic [7:0]  model_mask;
	int          model_commits;
	int          cmds_accepted;
	int          value_errors;
	int          protocol_errors;
	int          cycle_count;

	lane_unit DUT (
		.clock   (clock),
		.reset   (reset),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [3:0] random_alu_op();
		logic [31:0] r;
		r = next_random();
		return 4'(32'd1 + (r >> 16) % 32'd9);   // ADD up to LDI
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// APB master, called 5 ns after a rising edge
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clock);
		#5;
		penable = 1'b1;
		@(negedge clock);
		while (!pready) begin    // Wait states
			@(negedge clock);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clock);
		#5;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_no_error(input logic err, input logic [7:0] addr);
		assert (err == 1'b0) else begin
			$display("Slave error on a legal access to offset 0x%02h at %0t", addr, $time);
			protocol_errors++;
		end
	endtask

	task automatic check_bad_access(input logic write, input logic [7:0] addr);
		logic [31:0] data;
		logic        err;
		apb_transfer(write, addr, 32'hdead_beef, data, err);
		assert (err == 1'b1) else begin
			$display("No slave error on an illegal %s of offset 0x%02h at %0t",
				write ? "write" : "read", addr, $time);
			protocol_errors++;
		end
	endtask

	task automatic read_checked(input logic [7:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] data;
		logic        err;
		apb_transfer(1'b0, addr, 32'd0, data, err);
		check_no_error(err, addr);
		check_value(name, data, expected);
	endtask

	task automatic write_reg(input logic [3:0] idx, input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		logic [7:0]  addr;
		addr = `LANE_ADDR_REG_BASE + {2'b00, idx, 2'b00};
		apb_transfer(1'b1, addr, data, unused, err);
		check_no_error(err, addr);
		model_regs[idx] = data;
	endtask

	// Register reads wait for an empty pipeline, so STATUS after them is final
	task automatic check_all_state();
		logic [31:0] exp_status;
		int          k;
		for (k = 0; k < 16; k++) begin
			read_checked(`LANE_ADDR_REG_BASE + 8'(4 * k), model_regs[k],
				$sformatf("prdata reg %0d", k));
		end
		exp_status = {7'd0, 1'b1, model_mask, 16'(model_commits)};
		read_checked(`LANE_ADDR_STATUS, exp_status, "prdata status");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model, applied in issue order
	task automatic update_model(input logic [3:0] op, input logic [3:0] dst,
		input logic [3:0] src1, input logic [3:0] src2, input logic use_imm,
		input logic mask_en, input logic [2:0] mask_sel, input logic [10:0] imm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic        enabled;
		logic        is_cmp;
		a       = model_regs[src1];
		b       = (use_imm || op == lane_pkg::OP_LDI) ? {{21{imm[10]}}, imm} : model_regs[src2];
		enabled = !mask_en || model_mask[mask_sel];
		is_cmp  = (op == lane_pkg::OP_CMPLT) || (op == lane_pkg::OP_CMPEQ);
		case (op)
			lane_pkg::OP_ADD:   res = a + b;
			lane_pkg::OP_SUB:   res = a - b;
			lane_pkg::OP_AND:   res = a & b;
			lane_pkg::OP_OR:    res = a | b;
			lane_pkg::OP_XOR:   res = a ^ b;
			lane_pkg::OP_SHL:   res = a << b[4:0];
			lane_pkg::OP_SHR:   res = a >> b[4:0];
			lane_pkg::OP_MUL:   res = a * b;      // Low 32 bits kept
			lane_pkg::OP_LDI:   res = b;
			lane_pkg::OP_CMPLT: res = {31'd0, $signed(a) < $signed(b)};
			lane_pkg::OP_CMPEQ: res = {31'd0, a == b};
			default:            res = '0;
		endcase
		if (enabled && is_cmp) begin
			model_mask[dst[2:0]] = res[0];
		end else if (enabled && op != lane_pkg::OP_NOP) begin
			model_regs[dst] = res;
		end
		model_commits++;    // Masked off still commits
	endtask

	task automatic issue_cmd(input logic [3:0] op, input logic [3:0] dst,
		input logic [3:0] src1, input logic [3:0] src2, input logic use_imm,
		input logic mask_en, input logic [2:0] mask_sel, input logic [10:0] imm);
		logic [31:0] word;
		logic [31:0] unused;
		logic        err;
		word = {op, dst, src1, src2, use_imm, mask_en, mask_sel, imm};
		update_model(op, dst, src1, src2, use_imm, mask_en, mask_sel, imm);
		apb_transfer(1'b1, `LANE_ADDR_CMD, word, unused, err);
		check_no_error(err, `LANE_ADDR_CMD);
		if (!err) begin
			cmds_accepted++;
		end
	endtask

	task automatic issue_random(input logic [3:0] op, input logic mask_en);
		logic [31:0] r;
		logic [31:0] s;
		r = next_random();
		s = next_random();
		issue_cmd(op, r[31:28], r[27:24], r[23:20], r[19], mask_en, r[18:16], s[31:21]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	initial begin : stimulus
		int          i;
		logic [31:0] r;
		logic [31:0] s;
		logic [3:0]  prev;
		logic [3:0]  op;
		logic [31:0] status_word;
		logic        err;
		lcg_state       = 32'h03fb_2767;
		reset           = 1'b1;
		paddr           = 8'd0;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		pwdata          = 32'd0;
		value_errors    = 0;
		protocol_errors = 0;
		model_mask      = 8'd0;
		model_commits   = 0;
		cmds_accepted   = 0;
		for (i = 0; i < 16; i++) begin
			model_regs[i] = 32'd0;
		end
		repeat (2) @(posedge clock);
		#5;
		reset = 1'b0;

		check_all_state();    // Reset values

		for (i = 0; i < 16; i++) begin
			write_reg(4'(i), next_random());
		end
		check_all_state();
		check_bad_access(1'b1, `LANE_ADDR_STATUS);
		check_bad_access(1'b0, `LANE_ADDR_CMD);
		check_bad_access(1'b1, 8'h08);
		check_bad_access(1'b0, 8'h80);
		check_bad_access(1'b1, 8'h42);    // Misaligned register offset

		repeat (N_RANDOM) begin
			issue_random(random_alu_op(), 1'b0);
		end
		check_all_state();

		// Compares, half with equal sources so CMPEQ also hits
		for (i = 0; i < N_ROUNDS; i++) begin
			r  = next_random();
			s  = next_random();
			op = r[31] ? lane_pkg::OP_CMPLT : lane_pkg::OP_CMPEQ;
			issue_cmd(op, r[30:27], r[26:23], r[22] ? r[26:23] : r[21:18], r[17],
				r[16:14] == 3'd0, r[13:11], s[31:21]);
			issue_random(random_alu_op(), 1'b1);
			issue_random(random_alu_op(), 1'b1);
		end
		check_all_state();

		// Dependent chain in r0..r7 with independent loads to r8..r15 between
		issue_cmd(lane_pkg::OP_LDI, 4'd0, 4'd0, 4'd0, 1'b0, 1'b0, 3'd0, 11'h123);
		prev = 4'd0;
		for (i = 1; i <= N_CHAIN; i++) begin
			r = next_random();
			case (r[31:30])
				2'd0:    op = lane_pkg::OP_ADD;
				2'd1:    op = lane_pkg::OP_SUB;
				2'd2:    op = lane_pkg::OP_XOR;
				default: op = lane_pkg::OP_MUL;
			endcase
			issue_cmd(op, 4'(i % 8), prev, 4'd0, 1'b1, 1'b0, 3'd0, r[20:10]);
			prev = 4'(i % 8);
			issue_cmd(lane_pkg::OP_LDI, 4'(8 + i % 8), 4'd0, 4'd0, 1'b0, 1'b0, 3'd0, r[29:19]);
		end
		check_all_state();

		apb_transfer(1'b0, `LANE_ADDR_STATUS, 32'd0, status_word, err);
		check_no_error(err, `LANE_ADDR_STATUS);
		check_value("prdata status commit count", {16'd0, status_word[15:0]},
			{16'd0, 16'(cmds_accepted)});

		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		$display("Some tests failed");
		$finish;
	end

endmodule
